// File: verilog/icache_pkg.sv
package icache_pkg;

    // line geometry, one memory beat fills a whole line
    localparam int LINE_BYTES     = 64;
    localparam int OFFSET_WIDTH   = $clog2(LINE_BYTES);       // byte offset inside a line
    localparam int LINE_BITS      = LINE_BYTES * 8;
    localparam int FETCH_BITS     = 64;                       // two instruction words per fetch
    localparam int PAIRS_PER_LINE = LINE_BITS / FETCH_BITS;

    localparam int NUM_WAYS = 2;

    // answer words for a fetch that raised an exception
    localparam logic [31:0] INST_NOP = 32'h03400000;          // andi r0, r0, 0
    localparam logic [6:0]  EXC_ADEF = 7'h08;                 // fetch address error

    // a line is moved and stored flat, the response path picks one pair out of it
    // pair index is address bits 5:3
    typedef union packed {
        logic [LINE_BITS-1:0]                      flat;
        logic [PAIRS_PER_LINE-1:0][FETCH_BITS-1:0] pair;
    } line_t;

endpackage

// File: verilog/icache_sram.sv
`timescale 1ns/1ps

module icache_sram #(
    parameter int DATA_WIDTH  = 32,
    parameter int INDEX_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   i_we,
    input  logic [INDEX_WIDTH-1:0] i_waddr,
    input  logic [DATA_WIDTH-1:0]  i_wdata,
    input  logic [INDEX_WIDTH-1:0] i_raddr,
    output logic [DATA_WIDTH-1:0]  o_rdata
);

    logic [DATA_WIDTH-1:0] mem [0:(1 << INDEX_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read lands one cycle after the index, old data on a same-index write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

    waddr_known: assert property (@(posedge clk) i_we |-> !$isunknown(i_waddr))
        else $error("icache_sram: write with unknown address");

endmodule

// File: verilog/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store #(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = 32 - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [INDEX_WIDTH-1:0]          i_raddr,
    input  logic [TAG_WIDTH-1:0]            i_tag,      // tag of the buffered request
    input  logic [icache_pkg::NUM_WAYS-1:0] i_we,
    input  logic [INDEX_WIDTH-1:0]          i_waddr,
    input  logic [TAG_WIDTH-1:0]            i_wtag,
    input  logic                            i_wvalid,
    input  logic                            i_lru_we,
    input  logic                            i_lru_way,
    output logic [icache_pkg::NUM_WAYS-1:0] o_hit,
    output logic                            o_victim,
    output logic                            o_init_busy
);

    logic [INDEX_WIDTH-1:0]          init_idx;
    logic                            init_busy;
    logic [icache_pkg::NUM_WAYS-1:0] way_we;
    logic [INDEX_WIDTH-1:0]          way_waddr;
    logic [TAG_WIDTH:0]              way_wdata;              // {valid, tag}
    logic [TAG_WIDTH:0]              way_rdata [icache_pkg::NUM_WAYS];
    logic [(1 << INDEX_WIDTH)-1:0]   lru;                    // most recently used way per set

    // clear every valid bit once after reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            init_idx  <= '0;
            init_busy <= 1'b1;
        end else if (init_busy) begin
            init_idx <= init_idx + 1'b1;
            if (&init_idx) begin
                init_busy <= 1'b0;                          // last index written
            end
        end
    end

    assign o_init_busy = init_busy;

    // sweep owns the write port while it runs
    assign way_we    = init_busy ? '1 : i_we;
    assign way_waddr = init_busy ? init_idx : i_waddr;
    assign way_wdata = init_busy ? '0 : {i_wvalid, i_wtag};

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        icache_sram #(
            .DATA_WIDTH  (TAG_WIDTH + 1),
            .INDEX_WIDTH (INDEX_WIDTH)
        ) u_tagv (
            .clk     (clk),
            .i_we    (way_we[w]),
            .i_waddr (way_waddr),
            .i_wdata (way_wdata),
            .i_raddr (i_raddr),
            .o_rdata (way_rdata[w])
        );

        assign o_hit[w] = way_rdata[w][TAG_WIDTH] && (way_rdata[w][TAG_WIDTH-1:0] == i_tag);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (i_lru_we) begin
            lru[i_waddr] <= i_lru_way;
        end
    end

    // write index is the buffered request, so the victim holds through a miss
    assign o_victim = ~lru[i_waddr];

    // a refill never loads a line that is already present in the other way
    single_way_hit: assert property (@(posedge clk) disable iff (!rstn || init_busy)
        o_hit !== '1)
        else $error("icache_tag_store: both ways hit");

endmodule

// File: verilog/icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store #(
    parameter int INDEX_WIDTH = 6
) (
    input  logic                            clk,
    input  logic [INDEX_WIDTH-1:0]          i_raddr,
    input  logic [icache_pkg::NUM_WAYS-1:0] i_we,
    input  logic [INDEX_WIDTH-1:0]          i_waddr,
    input  icache_pkg::line_t               i_wline,
    input  logic                            i_way_sel,
    output icache_pkg::line_t               o_line
);

    logic [icache_pkg::LINE_BITS-1:0] way_rdata [icache_pkg::NUM_WAYS];

    // one line-wide array per way
    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        icache_sram #(
            .DATA_WIDTH  (icache_pkg::LINE_BITS),
            .INDEX_WIDTH (INDEX_WIDTH)
        ) u_data (
            .clk     (clk),
            .i_we    (i_we[w]),
            .i_waddr (i_waddr),
            .i_wdata (i_wline.flat),
            .i_raddr (i_raddr),
            .o_rdata (way_rdata[w])
        );
    end

    assign o_line.flat = way_rdata[i_way_sel];              // hit way, late select

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = 32 - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
    input  logic                              clk,
    input  logic                              rstn,
    // requester
    input  logic                              i_req_valid,
    input  logic [31:0]                       i_req_addr,
    input  logic                              i_req_inv,
    output logic                              o_req_ready,
    output logic                              o_resp_valid,
    output logic [icache_pkg::FETCH_BITS-1:0] o_resp_data,
    output logic [6:0]                        o_exc_code,
    output logic                              o_inv_done,
    // memory read channel
    output logic                              o_mem_rvalid,
    output logic [31:0]                       o_mem_raddr,
    input  logic                              i_mem_rready,
    input  icache_pkg::line_t                 i_mem_rdata,
    // stores
    output logic [INDEX_WIDTH-1:0]            o_rindex,
    output logic [INDEX_WIDTH-1:0]            o_windex,
    output logic [TAG_WIDTH-1:0]              o_tag,
    output logic [icache_pkg::NUM_WAYS-1:0]   o_tag_we,
    output logic [TAG_WIDTH-1:0]              o_wtag,
    output logic                              o_wvalid,
    output logic                              o_lru_we,
    output logic                              o_lru_way,
    output logic [icache_pkg::NUM_WAYS-1:0]   o_data_we,
    output logic                              o_way_sel,
    output icache_pkg::line_t                 o_wline,
    input  logic [icache_pkg::NUM_WAYS-1:0]   i_hit,
    input  logic                              i_victim,
    input  logic                              i_init_busy,
    input  icache_pkg::line_t                 i_line
);

    localparam logic [2:0] IDLE   = 3'd0;
    localparam logic [2:0] LOOKUP = 3'd1;
    localparam logic [2:0] MISS   = 3'd2;
    localparam logic [2:0] REFILL = 3'd3;
    localparam logic [2:0] INVAL  = 3'd4;

    logic [2:0]                      state;
    logic [2:0]                      next_state;
    logic [31:0]                     req_addr_q;
    logic                            req_inv_q;
    icache_pkg::line_t               ret_buf;               // the one memory beat
    logic                            accept;
    logic                            answer_now;
    logic                            misaligned;
    logic [2:0]                      pair_sel;
    logic [icache_pkg::NUM_WAYS-1:0] victim_oh;
    logic [icache_pkg::NUM_WAYS-1:0] inval_oh;

    assign misaligned = req_addr_q[1:0] != 2'b00;
    assign pair_sel   = req_addr_q[icache_pkg::OFFSET_WIDTH-1:3];
    assign victim_oh  = {i_victim, ~i_victim};
    assign inval_oh   = {req_addr_q[0], ~req_addr_q[0]};    // bit 0 picks the way

    // lookup that answers this cycle frees the request slot
    assign answer_now  = (state == LOOKUP) && (misaligned || (|i_hit));
    assign o_req_ready = ((state == IDLE) && !i_init_busy) || answer_now;
    assign accept      = i_req_valid && o_req_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= IDLE;
            req_inv_q <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                req_inv_q <= i_req_inv;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= i_req_addr;
        end
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    // stores are read with the incoming address, written with the buffered one
    assign o_rindex = i_req_addr[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
    assign o_windex = req_addr_q[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
    assign o_tag    = req_addr_q[31 -: TAG_WIDTH];
    assign o_wtag   = req_addr_q[31 -: TAG_WIDTH];
    assign o_wvalid = !req_inv_q;                           // an invalidate writes valid low
    assign o_way_sel = i_hit[1];
    assign o_wline   = ret_buf;

    assign o_mem_rvalid = state == MISS;
    assign o_mem_raddr  = {req_addr_q[31:icache_pkg::OFFSET_WIDTH],
                           {icache_pkg::OFFSET_WIDTH{1'b0}}};

    always_comb begin
        next_state   = state;
        o_resp_valid = 1'b0;
        o_resp_data  = i_line.pair[pair_sel];
        o_exc_code   = '0;
        o_inv_done   = 1'b0;
        o_tag_we     = '0;
        o_data_we    = '0;
        o_lru_we     = 1'b0;
        o_lru_way    = i_hit[1];
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = i_req_inv ? INVAL : LOOKUP;
                end
            end
            LOOKUP: begin
                if (misaligned) begin
                    o_resp_valid = 1'b1;
                    o_resp_data  = {icache_pkg::INST_NOP, icache_pkg::INST_NOP};
                    o_exc_code   = icache_pkg::EXC_ADEF;
                end else if (|i_hit) begin
                    o_resp_valid = 1'b1;
                    o_lru_we     = 1'b1;                    // hit way becomes most recent
                end
                if (!answer_now) begin
                    next_state = MISS;
                end else if (accept) begin
                    next_state = i_req_inv ? INVAL : LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                o_resp_valid = 1'b1;
                o_resp_data  = ret_buf.pair[pair_sel];
                o_tag_we     = victim_oh;
                o_data_we    = victim_oh;
                o_lru_we     = 1'b1;
                o_lru_way    = i_victim;
                next_state   = IDLE;
            end
            INVAL: begin
                o_tag_we   = inval_oh;
                o_inv_done = 1'b1;
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr))
        else $error("icache_ctrl: memory read request changed before rready");

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_WIDTH   = 32 - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              i_req_valid,
    input  logic [31:0]                       i_req_addr,
    input  logic                              i_req_inv,
    output logic                              o_req_ready,
    output logic                              o_resp_valid,
    output logic [icache_pkg::FETCH_BITS-1:0] o_resp_data,
    output logic [6:0]                        o_exc_code,
    output logic                              o_inv_done,
    output logic                              o_mem_rvalid,
    output logic [31:0]                       o_mem_raddr,
    input  logic                              i_mem_rready,
    input  icache_pkg::line_t                 i_mem_rdata
);

    logic [INDEX_WIDTH-1:0]          rindex;
    logic [INDEX_WIDTH-1:0]          windex;
    logic [TAG_WIDTH-1:0]            tag;
    logic [TAG_WIDTH-1:0]            wtag;
    logic [icache_pkg::NUM_WAYS-1:0] tag_we;
    logic [icache_pkg::NUM_WAYS-1:0] data_we;
    logic [icache_pkg::NUM_WAYS-1:0] hit;
    logic                            wvalid;
    logic                            lru_we;
    logic                            lru_way;
    logic                            way_sel;
    logic                            victim;
    logic                            init_busy;
    icache_pkg::line_t               wline;
    icache_pkg::line_t               line;

    icache_ctrl #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_req_inv    (i_req_inv),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_exc_code   (o_exc_code),
        .o_inv_done   (o_inv_done),
        .o_mem_rvalid (o_mem_rvalid),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata),
        .o_rindex     (rindex),
        .o_windex     (windex),
        .o_tag        (tag),
        .o_tag_we     (tag_we),
        .o_wtag       (wtag),
        .o_wvalid     (wvalid),
        .o_lru_we     (lru_we),
        .o_lru_way    (lru_way),
        .o_data_we    (data_we),
        .o_way_sel    (way_sel),
        .o_wline      (wline),
        .i_hit        (hit),
        .i_victim     (victim),
        .i_init_busy  (init_busy),
        .i_line       (line)
    );

    icache_tag_store #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_tag_store (
        .clk         (clk),
        .rstn        (rstn),
        .i_raddr     (rindex),
        .i_tag       (tag),
        .i_we        (tag_we),
        .i_waddr     (windex),
        .i_wtag      (wtag),
        .i_wvalid    (wvalid),
        .i_lru_we    (lru_we),
        .i_lru_way   (lru_way),
        .o_hit       (hit),
        .o_victim    (victim),
        .o_init_busy (init_busy)
    );

    icache_data_store #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_data_store (
        .clk       (clk),
        .i_raddr   (rindex),
        .i_we      (data_we),
        .i_waddr   (windex),
        .i_wline   (wline),
        .i_way_sel (way_sel),
        .o_line    (line)
    );

endmodule

// File: sim/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int INDEX_WIDTH  = 6;
    localparam int TAG_W        = 32 - INDEX_WIDTH - icache_pkg::OFFSET_WIDTH;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_REQ      = 2000;
    // room for every request plus the valid sweep after reset
    localparam int WATCHDOG_NS  =
        (NUM_REQ * 12 + (1 << INDEX_WIDTH) + RESET_CYCLES + 16) * CLK_PERIOD;
    localparam logic [31:0] MEM_PATTERN = 32'h5a5a0000;

    localparam int K_HIT   = 0;
    localparam int K_MISS  = 1;
    localparam int K_MISAL = 2;
    localparam int K_INV   = 3;

    logic              clk = 1'b0;
    logic              rstn;
    logic              i_req_valid;
    logic [31:0]       i_req_addr;
    logic              i_req_inv;
    logic              o_req_ready;
    logic              o_resp_valid;
    logic [63:0]       o_resp_data;
    logic [6:0]        o_exc_code;
    logic              o_inv_done;
    logic              o_mem_rvalid;
    logic [31:0]       o_mem_raddr;
    logic              i_mem_rready;
    icache_pkg::line_t i_mem_rdata;

    integer seed = 32'h968d;

    // reference model of the tag arrays
    logic [TAG_W-1:0] m_tag   [2][1 << INDEX_WIDTH];
    bit               m_valid [2][1 << INDEX_WIDTH];
    bit               m_lru   [1 << INDEX_WIDTH];       // most recently used way

    // the one request in flight
    bit          pend;
    int          pend_kind;
    int unsigned pend_acc;
    int unsigned pend_hs;
    bit          pend_hs_seen;
    logic [63:0] pend_data;
    logic [6:0]  pend_exc;
    logic [31:0] pend_line;

    int unsigned cyc;
    int unsigned n_sent;
    int unsigned n_done;
    int unsigned n_hit;
    int unsigned n_miss;
    int unsigned n_misal;
    int unsigned n_inv;
    int unsigned n_b2b;
    bit          answered_now;
    bit          mem_armed;
    int unsigned mem_wait;

    icache_top #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_icache_top (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_req_inv    (i_req_inv),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_exc_code   (o_exc_code),
        .o_inv_done   (o_inv_done),
        .o_mem_rvalid (o_mem_rvalid),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rready (i_mem_rready),
        .i_mem_rdata  (i_mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                     name, got, exp, cyc);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // backing memory, each word holds its own byte address scrambled
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return byte_addr ^ MEM_PATTERN;
    endfunction

    function automatic icache_pkg::line_t mem_line(input logic [31:0] line_addr);
        icache_pkg::line_t line;
        for (int k = 0; k < icache_pkg::LINE_BYTES / 4; k++) begin
            line.flat[32*k +: 32] = mem_word(line_addr + 32'(4 * k));
        end
        return line;
    endfunction

    function automatic logic [63:0] fetch_pair(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};   // lower address in low half
    endfunction

    function automatic logic [TAG_W-1:0] pool_tag(input int unsigned sel);
        case (sel)
            0:       return 20'h00010;
            1:       return 20'h00a37;
            default: return 20'h1c005;
        endcase
    endfunction

    function automatic logic [INDEX_WIDTH-1:0] pool_index(input int unsigned sel);
        case (sel)
            0:       return 6'h00;
            1:       return 6'h05;
            2:       return 6'h2a;
            default: return 6'h3f;
        endcase
    endfunction

    function automatic logic [31:0] pool_addr(input logic inv);
        logic [TAG_W-1:0]                   tag;
        logic [INDEX_WIDTH-1:0]             idx;
        logic [icache_pkg::OFFSET_WIDTH-1:0] off;
        logic [31:0]                        rnd;
        tag = pool_tag(rand_below(3));
        idx = pool_index(rand_below(4));
        rnd = rand_below(64);
        off = rnd[icache_pkg::OFFSET_WIDTH-1:0];
        if (inv) begin
            off[1:0] = {1'b0, rnd[0]};                     // way to clear
        end else if (rand_below(100) < 10) begin
            rnd = 1 + rand_below(3);
            off[1:0] = rnd[1:0];
        end else begin
            off[1:0] = 2'b00;
        end
        return {tag, idx, off};
    endfunction

    // apply one accepted request to the model and note what the DUT owes
    task automatic model_accept(input logic [31:0] addr, input logic inv);
        logic [INDEX_WIDTH-1:0] idx;
        logic [TAG_W-1:0]       tg;
        logic                   h0;
        logic                   h1;
        logic                   vic;
        idx          = addr[icache_pkg::OFFSET_WIDTH +: INDEX_WIDTH];
        tg           = addr[31 -: TAG_W];
        pend         = 1'b1;
        pend_acc     = cyc;
        pend_hs_seen = 1'b0;
        pend_exc     = '0;
        pend_data    = fetch_pair(addr);
        pend_line    = {addr[31:icache_pkg::OFFSET_WIDTH], {icache_pkg::OFFSET_WIDTH{1'b0}}};
        if (inv) begin
            pend_kind = K_INV;
            m_valid[addr[0]][idx] = 1'b0;
        end else if (addr[1:0] != 2'b00) begin
            pend_kind = K_MISAL;                           // lru left alone
            pend_data = {icache_pkg::INST_NOP, icache_pkg::INST_NOP};
            pend_exc  = icache_pkg::EXC_ADEF;
        end else begin
            h0 = m_valid[0][idx] && (m_tag[0][idx] == tg);
            h1 = m_valid[1][idx] && (m_tag[1][idx] == tg);
            if (h0 || h1) begin
                pend_kind = K_HIT;
                m_lru[idx] = h1;
            end else begin
                pend_kind = K_MISS;
                vic = !m_lru[idx];
                m_tag[vic][idx]   = tg;
                m_valid[vic][idx] = 1'b1;
                m_lru[idx]        = vic;
            end
        end
    endtask

    // outputs sampled here are the settled values of the cycle just ended
    task automatic check_cycle();
        logic resp_exp;
        logic inv_exp;
        logic rvalid_exp;
        logic ready_exp;
        resp_exp = pend && ((((pend_kind == K_HIT) || (pend_kind == K_MISAL))
                             && (cyc == pend_acc + 1))
                            || ((pend_kind == K_MISS) && pend_hs_seen && (cyc == pend_hs + 1)));
        inv_exp    = pend && (pend_kind == K_INV) && (cyc == pend_acc + 1);
        rvalid_exp = pend && (pend_kind == K_MISS) && !pend_hs_seen && (cyc > pend_acc + 1);
        ready_exp  = !pend || (resp_exp && (pend_kind != K_MISS));
        answered_now = resp_exp && (pend_kind != K_MISS);
        check_value("o_resp_valid", o_resp_valid, resp_exp);
        check_value("o_inv_done", o_inv_done, inv_exp);
        check_value("o_mem_rvalid", o_mem_rvalid, rvalid_exp);
        check_value("o_req_ready", o_req_ready, ready_exp);
        if (resp_exp) begin
            check_value("o_resp_data", o_resp_data, pend_data);
            check_value("o_exc_code", o_exc_code, pend_exc);
            case (pend_kind)
                K_HIT:   n_hit++;
                K_MISS:  n_miss++;
                default: n_misal++;
            endcase
            pend = 1'b0;
            n_done++;
        end
        if (inv_exp) begin
            n_inv++;
            pend = 1'b0;
            n_done++;
        end
        if (rvalid_exp) begin
            check_value("o_mem_raddr", o_mem_raddr, pend_line);
            if (i_mem_rready) begin
                pend_hs_seen = 1'b1;
                pend_hs      = cyc;
            end
        end
    endtask

    task automatic respond_memory();
        if (o_mem_rvalid && i_mem_rready) begin
            i_mem_rready <= 1'b0;
            i_mem_rdata  <= '0;
            mem_armed = 1'b0;
        end else if (o_mem_rvalid) begin
            if (!mem_armed) begin
                mem_wait  = rand_below(6);
                mem_armed = 1'b1;
            end
            if (mem_wait == 0) begin
                i_mem_rready <= 1'b1;
                i_mem_rdata  <= mem_line(o_mem_raddr);
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    endtask

    task automatic drive_next_request();
        logic        inv;
        logic [31:0] addr;
        if ((n_sent >= NUM_REQ) || (rand_below(100) < 15)) begin
            i_req_valid <= 1'b0;                           // idle gap
            i_req_inv   <= 1'b0;
        end else begin
            inv  = rand_below(100) < 10;
            addr = pool_addr(inv);
            i_req_valid <= 1'b1;
            i_req_inv   <= inv;
            i_req_addr  <= addr;
        end
    endtask

    task automatic take_request();
        if (i_req_valid && o_req_ready) begin
            if (answered_now) begin
                n_b2b++;
            end
            model_accept(i_req_addr, i_req_inv);
            n_sent++;
            drive_next_request();
        end else if (!i_req_valid) begin
            drive_next_request();
        end
    endtask

    initial begin
        rstn         = 1'b0;
        i_req_valid  = 1'b0;
        i_req_addr   = '0;
        i_req_inv    = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        while (o_req_ready !== 1'b1) @(posedge clk);     // valid sweep running
        check_value("o_resp_valid", o_resp_valid, 1'b0);
        check_value("o_inv_done", o_inv_done, 1'b0);
        check_value("o_mem_rvalid", o_mem_rvalid, 1'b0);
        drive_next_request();
        while (n_done < NUM_REQ) begin
            @(posedge clk);
            cyc++;
            check_cycle();
            respond_memory();
            take_request();
        end
        $display("%0d requests: %0d hits, %0d misses, %0d misaligned, %0d invalidates",
                 n_done, n_hit, n_miss, n_misal, n_inv);
        $display("%0d fetches accepted in the answer cycle of the one before", n_b2b);
        if ((n_hit == 0) || (n_miss == 0) || (n_misal == 0) || (n_inv == 0) || (n_b2b == 0)) begin
            $display("random stimulus did not reach every kind of request");
            $display("TEST RESULT: FAIL");
            $fatal(1, "stimulus gap");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, %0d of %0d requests done",
                 WATCHDOG_NS, n_done, NUM_REQ);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog.f
verilog/icache_pkg.sv
verilog/icache_sram.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_sram.sv
      - verilog/icache_tag_store.sv
      - verilog/icache_data_store.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_top.sv
  - target: simulation
    files:
      - sim/icache_tb.sv
